// File: list.f
common/psram_pkg.sv
rtl/psram_host_port.sv
psram_ctrl/psram_ctrl.sv
rtl/psram_subsys.sv
sim/psram_model.sv
sim/tb_psram.sv

// File: Bender.yml
package:
  name: psram_subsys

sources:
  - common/psram_pkg.sv
  - rtl/psram_host_port.sv
  - psram_ctrl/psram_ctrl.sv
  - rtl/psram_subsys.sv
  - target: simulation
    files:
      - sim/psram_model.sv
      - sim/tb_psram.sv

// File: sim/tb_psram.sv
`timescale 1ns/100ps

module tb_psram;
    import psram_pkg::*;

    localparam int CMD_COUNT   = 45;
    localparam int WATCHDOG_NS = (CMD_COUNT * (8 + 16 + 4) + 200) * 20;

    logic              clk50MHz;
    logic              rst_n;
    logic              req;
    psram_cmd_t        cmd;
    logic              ack;
    logic [DATA_W-1:0] wdata;
    logic              wnext;
    logic [DATA_W-1:0] rdata;
    logic              rvalid;
    psram_pins_t       pins;
    logic              mclk;
    logic [DATA_W-1:0] dq_out;
    logic              dq_oe;
    logic [DATA_W-1:0] dq_in;
    logic              mwait;

    logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] exp_q [$];
    logic [DATA_W-1:0] wr_words [$];
    logic              wnext_seen = 1'b0;
    int                wr_idx = 0;
    int                cyc = 0;
    int                wnext_cnt = 0;
    int                rvalid_cnt = 0;
    int                madv_cnt = 0;
    int                mclk_cnt = 0;
    int                mismatches = 0;
    int                faults = 0;
    string             test_name = "reset";

    psram_subsys dut0 (.*);
    psram_model model0 (.*);

    initial begin
        clk50MHz = 1'b0;
        forever #10 clk50MHz = ~clk50MHz;
    end

    // Last written value or the fill pattern
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a[15:0] ^ {8'h00, a[23:16]} ^ 16'hA5C3;
    endfunction

    task automatic report_fault(input string msg);
        faults++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            mismatches++;
            $display("Mismatch in %s (%s): expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    always @(posedge clk50MHz) begin
        cyc <= cyc + 1;
    end

    always @(posedge mclk) begin
        if (rst_n) begin
            mclk_cnt++;
        end
    end

    // Next write word goes out in the cycle after each wnext
    always @(posedge clk50MHz) begin
        #2;
        if (wnext_seen) begin
            wr_idx++;
        end
        if (wr_idx < wr_words.size()) begin
            wdata = wr_words[wr_idx];
        end
    end

    // Monitors and read data compare at mid-cycle
    always @(negedge clk50MHz) begin
        logic [DATA_W-1:0] exp_word;
        wnext_seen = wnext;
        if (rst_n) begin
            if (wnext) begin
                wnext_cnt++;
            end
            if (!pins.madv_n) begin
                madv_cnt++;
            end
            assert (!(dq_oe && !pins.moe_n)) else report_fault("dq_oe high while moe_n low");
            assert (req || ack || pins.mce_n) else report_fault("mce_n low outside a burst");
            assert (!pins.mcre && !pins.mub_n && !pins.mlb_n)
                else report_fault("mcre high or a byte lane disabled");
            if (rvalid) begin
                rvalid_cnt++;
                assert (exp_q.size() > 0)
                    else report_fault("rvalid with no read word pending");
                if (exp_q.size() > 0) begin
                    exp_word = exp_q.pop_front();
                    assert (rdata == exp_word) else begin
                        mismatches++;
                        $display("Mismatch in %s: expected %h, actual %h",
                                 test_name, exp_word, rdata);
                    end
                end
            end
        end
    end

    // One four-phase transaction with req held for hold extra cycles after ack
    task automatic run_cmd(input logic [ADDR_W-1:0] addr, input int len, input logic write,
                           input int hold);
        int                req_cyc;
        int                waited;
        int                w0;
        int                r0;
        int                m0;
        logic [DATA_W-1:0] w;
        wr_idx = 0;
        wr_words.delete();
        for (int i = 0; i < len; i++) begin
            if (write) begin
                w = DATA_W'($urandom);
                wr_words.push_back(w);
                ref_mem[addr + ADDR_W'(i)] = w;
            end else begin
                exp_q.push_back(expected_word(addr + ADDR_W'(i)));
            end
        end
        w0 = wnext_cnt;
        r0 = rvalid_cnt;
        m0 = madv_cnt;
        @(posedge clk50MHz);
        #2;
        cmd.addr  = addr;
        cmd.len   = burst_len_t'(len - 1);
        cmd.write = write;
        req       = 1'b1;
        req_cyc   = cyc;
        waited    = 0;
        @(negedge clk50MHz);
        while (!ack && waited < 40) begin
            @(negedge clk50MHz);
            waited++;
        end
        assert (ack) else report_fault("ack never rose");
        check_value("ack latency", 8 + len, cyc - req_cyc);
        repeat (hold) begin
            @(negedge clk50MHz);
            assert (ack) else report_fault("ack dropped while req was held");
        end
        @(posedge clk50MHz);
        #2;
        req    = 1'b0;
        waited = 0;
        @(negedge clk50MHz);
        while (ack && waited < 8) begin
            @(negedge clk50MHz);
            waited++;
        end
        assert (!ack) else report_fault("ack did not fall after req was released");
        check_value("wnext pulses", write ? len : 0, wnext_cnt - w0);
        check_value("rvalid pulses", write ? 0 : len, rvalid_cnt - r0);
        check_value("madv_n cycles", 1, madv_cnt - m0);
    endtask

    initial begin
        logic [ADDR_W-1:0] a;
        int                n;
        logic              wr;
        void'($urandom(93));
        rst_n = 1'b0;
        req   = 1'b0;
        cmd   = '0;
        wdata = '0;
        mwait = 1'b0;
        repeat (8) @(posedge clk50MHz);
        #2;
        rst_n = 1'b1;
        repeat (3) @(negedge clk50MHz);
        assert (!ack && !rvalid && !wnext && pins.mce_n && mclk_cnt == 0)
            else report_fault("outputs not idle after reset");

        test_name = "single_read";
        a = ADDR_W'($urandom);
        run_cmd(a, 1, 1'b0, 0);

        test_name = "burst_write";
        a = ADDR_W'($urandom);
        run_cmd(a, 16, 1'b1, 0);
        test_name = "burst_readback";
        run_cmd(a, 16, 1'b0, 0);

        // Small window so reads hit earlier writes
        test_name = "random_seq";
        repeat (40) begin
            a  = 24'h3C0000 + ADDR_W'($urandom_range(0, 127));
            n  = $urandom_range(1, 16);
            wr = 1'($urandom_range(0, 1));
            run_cmd(a, n, wr, 0);
        end

        test_name = "handshake";
        run_cmd(a, 4, 1'b1, 5);
        run_cmd(a, 4, 1'b0, 0);

        $display("Summary: %0d mismatches, %0d other errors, %0d read words checked",
                 mismatches, faults, rvalid_cnt);
        if (mismatches + faults == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run hung: tests did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: sim/psram_model.sv
`timescale 1ns/100ps

// Behavioral burst pseudo-SRAM with fixed latency
module psram_model (
    input  psram_pkg::psram_pins_t       pins,
    input  logic                         mclk,
    input  logic [psram_pkg::DATA_W-1:0] dq_out,
    input  logic                         dq_oe,
    output logic [psram_pkg::DATA_W-1:0] dq_in
);
    import psram_pkg::*;

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    logic [ADDR_W-1:0] base;
    int                lat;
    int                rd_idx;
    int                wr_idx;

    // Words never written hold a pattern of the full address
    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[15:0] ^ {8'h00, a[23:16]} ^ 16'hA5C3;
    endfunction

    initial begin
        dq_in = '0;
    end

    always @(posedge mclk) begin
        if (!pins.mce_n && !pins.madv_n) begin
            base   = pins.maddr;
            lat    = 0;
            rd_idx = 0;
            wr_idx = 0;
        end else if (!pins.mce_n) begin
            // Write words arrive one edge later than read words leave
            if (!pins.mwe_n && dq_oe) begin
                mem[base + ADDR_W'(wr_idx)] = dq_out;
                wr_idx++;
            end
            if (lat < RW_LATENCY) begin
                lat++;
            end
            if (lat == RW_LATENCY) begin
                dq_in <= read_word(base + ADDR_W'(rd_idx));
                rd_idx++;
            end
        end
    end

endmodule

// File: rtl/psram_subsys.sv
`timescale 1ns/100ps

// Host port plus burst controller
module psram_subsys (
    input  logic                         clk50MHz,
    input  logic                         rst_n,
    input  logic                         req,
    input  psram_pkg::psram_cmd_t        cmd,
    output logic                         ack,
    input  logic [psram_pkg::DATA_W-1:0] wdata,
    output logic                         wnext,
    output logic [psram_pkg::DATA_W-1:0] rdata,
    output logic                         rvalid,
    output psram_pkg::psram_pins_t       pins,
    output logic                         mclk,
    output logic [psram_pkg::DATA_W-1:0] dq_out,
    output logic                         dq_oe,
    input  logic [psram_pkg::DATA_W-1:0] dq_in,
    input  logic                         mwait
);
    import psram_pkg::*;

    logic       start;
    logic       done;
    psram_cmd_t burst_cmd;

    psram_host_port host_port0 (
        .clk50MHz  (clk50MHz),
        .rst_n     (rst_n),
        .req       (req),
        .cmd       (cmd),
        .ack       (ack),
        .start     (start),
        .burst_cmd (burst_cmd),
        .done      (done)
    );

    psram_ctrl ctrl0 (
        .clk50MHz  (clk50MHz),
        .rst_n     (rst_n),
        .start     (start),
        .burst_cmd (burst_cmd),
        .done      (done),
        .wdata     (wdata),
        .wnext     (wnext),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .pins      (pins),
        .mclk      (mclk),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in),
        .mwait     (mwait)
    );

endmodule

// File: psram_ctrl/psram_ctrl.sv
`timescale 1ns/100ps

// Fixed-latency burst controller for a 16-bit cellular RAM
module psram_ctrl (
    input  logic                         clk50MHz,
    input  logic                         rst_n,
    input  logic                         start,
    input  psram_pkg::psram_cmd_t        burst_cmd,
    output logic                         done,
    input  logic [psram_pkg::DATA_W-1:0] wdata,
    output logic                         wnext,
    output logic [psram_pkg::DATA_W-1:0] rdata,
    output logic                         rvalid,
    output psram_pkg::psram_pins_t       pins,
    output logic                         mclk,
    output logic [psram_pkg::DATA_W-1:0] dq_out,
    output logic                         dq_oe,
    input  logic [psram_pkg::DATA_W-1:0] dq_in,
    input  logic                         mwait
);
    import psram_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic [1:0]  lat_cnt;
    burst_len_t  burst_cnt;
    logic        lat_last;
    logic        burst_last;
    logic        in_wait;
    logic        in_data;
    logic        mclk_en;

    // Latency is fixed, so mwait is never consulted

    assign in_wait    = (state == READ_WAIT) || (state == WRITE_WAIT);
    assign in_data    = (state == READ_DATA) || (state == WRITE_DATA);
    assign lat_last   = (lat_cnt == 2'(RW_LATENCY - 1));
    assign burst_last = (burst_cnt == burst_cmd.len);

    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = burst_cmd.write ? WRITE_WAIT : READ_WAIT;
                end
            end
            READ_WAIT: begin
                if (lat_last) begin
                    state_nxt = READ_DATA;
                end
            end
            READ_DATA: begin
                if (burst_last) begin
                    state_nxt = FINISH;
                end
            end
            WRITE_WAIT: begin
                if (lat_last) begin
                    state_nxt = WRITE_DATA;
                end
            end
            WRITE_DATA: begin
                if (burst_last) begin
                    state_nxt = FINISH;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Latency and burst counters, cleared between bursts
    always_ff @(posedge clk50MHz) begin
        if (!rst_n || state == IDLE || state == FINISH) begin
            lat_cnt   <= '0;
            burst_cnt <= '0;
        end else begin
            if (in_wait) begin
                lat_cnt <= lat_cnt + 2'd1;
            end
            if (in_data) begin
                burst_cnt <= burst_cnt + 4'd1;
            end
        end
    end

    // Strobe decode
    always_comb begin
        pins.maddr  = burst_cmd.addr;
        pins.moe_n  = 1'b1;
        pins.mwe_n  = 1'b1;
        pins.madv_n = 1'b1;
        pins.mce_n  = 1'b1;
        pins.mub_n  = 1'b0;
        pins.mlb_n  = 1'b0;
        pins.mcre   = 1'b0;
        dq_oe       = 1'b0;
        wnext       = 1'b0;
        done        = 1'b0;
        case (state)
            IDLE: begin
                // Address phase coincides with start
                if (start) begin
                    pins.madv_n = 1'b0;
                    pins.mce_n  = 1'b0;
                end
            end
            READ_WAIT, WRITE_WAIT: begin
                pins.mce_n = 1'b0;
            end
            READ_DATA: begin
                pins.mce_n = 1'b0;
                pins.moe_n = 1'b0;
            end
            WRITE_DATA: begin
                pins.mce_n = 1'b0;
                pins.mwe_n = 1'b0;
                dq_oe      = 1'b1;
                wnext      = 1'b1;
            end
            FINISH: begin
                done = 1'b1;
            end
            default: begin
                done = 1'b0;
            end
        endcase
    end

    assign dq_out = wdata;

    // Read data capture
    always_ff @(posedge clk50MHz) begin
        if (state == READ_DATA) begin
            rdata <= dq_in;
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= (state == READ_DATA);
        end
    end

    // Clock enable changes while clk50MHz is low, keeping mclk glitch free
    always_ff @(negedge clk50MHz) begin
        if (!rst_n) begin
            mclk_en <= 1'b0;
        end else if (state == IDLE) begin
            mclk_en <= start;
        end else begin
            mclk_en <= (state != FINISH);
        end
    end

    assign mclk = clk50MHz & mclk_en;

endmodule

// File: rtl/psram_host_port.sv
`timescale 1ns/100ps

// Four-phase req/ack slave, launches one controller burst per transaction
module psram_host_port (
    input  logic                  clk50MHz,
    input  logic                  rst_n,
    input  logic                  req,
    input  psram_pkg::psram_cmd_t cmd,
    output logic                  ack,
    output logic                  start,
    output psram_pkg::psram_cmd_t burst_cmd,
    input  logic                  done
);
    import psram_pkg::*;

    typedef enum logic [1:0] {
        WAIT_REQ,
        BUSY,
        WAIT_REL
    } port_state_t;

    port_state_t state;
    logic        req_q;

    // Registered request from the host
    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req;
        end
    end

    // Handshake FSM
    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            state <= WAIT_REQ;
            start <= 1'b0;
            ack   <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                WAIT_REQ: begin
                    if (req_q) begin
                        start <= 1'b1;
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    // Burst complete, answer the host
                    if (done) begin
                        ack   <= 1'b1;
                        state <= WAIT_REL;
                    end
                end
                WAIT_REL: begin
                    if (!req_q) begin
                        ack   <= 1'b0;
                        state <= WAIT_REQ;
                    end
                end
                default: begin
                    ack   <= 1'b0;
                    state <= WAIT_REQ;
                end
            endcase
        end
    end

    // Command held for the whole burst
    always_ff @(posedge clk50MHz) begin
        if (state == WAIT_REQ && req_q) begin
            burst_cmd <= cmd;
        end
    end

endmodule

// File: common/psram_pkg.sv
// Shared widths, timing and types for the pseudo-SRAM controller

package psram_pkg;

    // Word address and data widths of the device
    localparam int ADDR_W = 24;
    localparam int DATA_W = 16;

    // Wait cycles between address-valid and the first data word
    localparam int RW_LATENCY = 4;

    // Value n encodes a burst of n+1 words
    typedef logic [3:0] burst_len_t;

    // One host command
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        burst_len_t        len;
        logic              write;
    } psram_cmd_t;

    // Memory control pins, strobes active low except mcre
    typedef struct packed {
        logic [ADDR_W-1:0] maddr;
        logic              moe_n;
        logic              mwe_n;
        logic              madv_n;
        logic              mce_n;
        logic              mub_n;
        logic              mlb_n;
        logic              mcre;
    } psram_pins_t;

    // Burst controller states
    typedef enum logic [2:0] {
        IDLE,
        READ_WAIT,
        READ_DATA,
        WRITE_WAIT,
        WRITE_DATA,
        FINISH
    } ctrl_state_t;

endpackage
